// File: Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/mem_pkg.sv
  - source/refill_if.sv
  - source/tagv_array.sv
  - source/data_array.sv
  - source/refill_buffer.sv
  - source/icache_ctrl.sv
  - source/icache_top.sv
  - target: test
    files:
      - tests/icache_props.sv
      - tests/icache_tb.sv

// File: source/data_array.sv
`timescale 1ns/10ps

module data_array #(
    parameter int DEPTH = 128
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_ren,
    input  logic [$clog2(DEPTH)-1:0]      i_raddr,
    input  logic                          i_wen,
    input  logic [$clog2(DEPTH)-1:0]      i_waddr,
    input  logic [icache_pkg::LINE_W-1:0] i_wdata,
    output logic [icache_pkg::LINE_W-1:0] o_rdata
);
    import icache_pkg::*;

    logic [LINE_W-1:0] lines [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wen) begin
            lines[i_waddr] <= i_wdata;
        end
    end

    // registered read, same latency as an sram macro
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rdata <= '0;
        end else if (i_ren) begin
            o_rdata <= lines[i_raddr];
        end
    end

endmodule

// File: source/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_req,
    input  icache_pkg::fetch_addr_t        i_addr,
    output logic                           o_ready,
    output logic                           o_valid,
    output logic [mem_pkg::MEM_DATA_W-1:0] o_rdata,
    refill_if.ctrl                         rf,
    output logic [icache_pkg::INDEX_W-1:0] o_tag_raddr,
    output logic [icache_pkg::INDEX_W-1:0] o_tag_waddr,
    input  icache_pkg::tagv_t              i_tag_rdata [icache_pkg::WAYS],
    output logic [icache_pkg::WAYS-1:0]    o_tag_wen,
    output icache_pkg::tagv_t              o_tag_wdata,
    output logic                           o_data_ren,
    output logic [icache_pkg::INDEX_W-1:0] o_data_raddr,
    output logic [icache_pkg::WAYS-1:0]    o_data_wen,
    output logic [icache_pkg::INDEX_W-1:0] o_data_waddr,
    output logic [icache_pkg::LINE_W-1:0]  o_data_wdata,
    input  logic [icache_pkg::LINE_W-1:0]  i_data_rdata [icache_pkg::WAYS]
);
    import icache_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_MISS, S_FILL} state_t;

    state_t            state;
    state_t            state_nxt;
    logic [WAYS-1:0]   hit;
    logic              hit_any;
    logic              victim;
    logic              accept;
    logic [SETS-1:0]   ru_way;
    fetch_addr_t       addr_q;
    logic [WAYS-1:0]   hit_q;
    logic              victim_q;
    logic              from_fill;
    logic [LINE_W-1:0] hit_line;
    logic [LINE_W-1:0] out_line;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = i_tag_rdata[w].valid && (i_tag_rdata[w].tag == i_addr.f.tag);
        end
    end

    assign hit_any = |hit;

    // free way first (way 0 before way 1), else the one not used last
    always_comb begin
        if (!i_tag_rdata[0].valid) begin
            victim = 1'b0;
        end else if (!i_tag_rdata[1].valid) begin
            victim = 1'b1;
        end else begin
            victim = ~ru_way[i_addr.f.index];
        end
    end

    assign o_ready = (state == S_IDLE) || (state == S_READ);
    assign o_valid = (state == S_READ);
    assign accept  = i_req && o_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_READ: begin
                if (accept) begin
                    state_nxt = hit_any ? S_READ : S_MISS;
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            S_MISS: begin
                if (rf.done) begin
                    state_nxt = S_FILL;
                end
            end
            S_FILL: state_nxt = S_READ;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            from_fill <= 1'b0;
            ru_way    <= '0;
        end else begin
            state     <= state_nxt;
            from_fill <= (state == S_FILL);
            // hits mark on accept, misses once the line is in
            if (accept && hit_any) begin
                ru_way[i_addr.f.index] <= hit[1];
            end else if (state == S_FILL) begin
                ru_way[addr_q.f.index] <= victim_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= i_addr;
            hit_q    <= hit;
            victim_q <= victim;
        end
    end

    assign rf.start     = accept && !hit_any;
    assign rf.line_addr = {i_addr.raw[$bits(fetch_addr_t)-1:OFFSET_W], OFFSET_W'(0)};

    // lookup reads
    assign o_tag_raddr  = i_addr.f.index;
    assign o_data_raddr = i_addr.f.index;
    assign o_data_ren   = accept;

    // fill writes into the victim way
    assign o_tag_waddr  = addr_q.f.index;
    assign o_data_waddr = addr_q.f.index;
    assign o_tag_wdata  = '{tag: addr_q.f.tag, valid: 1'b1};
    assign o_data_wdata = rf.line;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            o_tag_wen[w] = (state == S_FILL) && (victim_q == 1'(w));
        end
    end

    assign o_data_wen = o_tag_wen;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_line = hit_line | ({LINE_W{hit_q[w]}} & i_data_rdata[w]);
        end
    end

    assign out_line = from_fill ? rf.line : hit_line;
    // offset bit 3 picks the 8-byte half
    assign o_rdata  = addr_q.f.offset[OFFSET_W-1] ? out_line[LINE_W-1 -: MEM_DATA_W]
                                                  : out_line[MEM_DATA_W-1:0];

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

    // fetch address split
    localparam int TAG_W    = 21;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 4;

    // geometry
    localparam int SETS   = 128;
    localparam int WAYS   = 2;
    localparam int LINE_W = 128;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // one fetch word, seen raw or as its fields
    typedef union packed {
        logic [TAG_W+INDEX_W+OFFSET_W-1:0] raw;
        addr_fields_t                      f;
    } fetch_addr_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tagv_t;

endpackage

// File: source/icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_req,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] i_addr,
    output logic                           o_ready,
    output logic                           o_valid,
    output logic [mem_pkg::MEM_DATA_W-1:0] o_rdata,
    output logic                           o_mem_req,
    output logic [mem_pkg::MEM_ADDR_W-1:0] o_mem_addr,
    input  logic                           i_mem_ready,
    input  logic [mem_pkg::MEM_DATA_W-1:0] i_mem_rdata,
    input  logic                           i_mem_rvalid,
    input  logic                           i_mem_rlast
);
    import icache_pkg::*;

    logic [INDEX_W-1:0] tag_raddr;
    logic [INDEX_W-1:0] tag_waddr;
    tagv_t              tag_rdata [WAYS];
    logic [WAYS-1:0]    tag_wen;
    tagv_t              tag_wdata;
    logic               data_ren;
    logic [INDEX_W-1:0] data_raddr;
    logic [WAYS-1:0]    data_wen;
    logic [INDEX_W-1:0] data_waddr;
    logic [LINE_W-1:0]  data_wdata;
    logic [LINE_W-1:0]  data_rdata [WAYS];

    refill_if rf_bus ();

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_rdata      (o_rdata),
        .rf           (rf_bus),
        .o_tag_raddr  (tag_raddr),
        .o_tag_waddr  (tag_waddr),
        .i_tag_rdata  (tag_rdata),
        .o_tag_wen    (tag_wen),
        .o_tag_wdata  (tag_wdata),
        .o_data_ren   (data_ren),
        .o_data_raddr (data_raddr),
        .o_data_wen   (data_wen),
        .o_data_waddr (data_waddr),
        .o_data_wdata (data_wdata),
        .i_data_rdata (data_rdata)
    );

    refill_buffer u_refill (
        .clk          (clk),
        .rst          (rst),
        .rf           (rf_bus),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rlast  (i_mem_rlast)
    );

    // one tag store and one line store per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        tagv_array #(
            .DEPTH (SETS)
        ) u_tagv (
            .clk     (clk),
            .rst     (rst),
            .i_wen   (tag_wen[w]),
            .i_waddr (tag_waddr),
            .i_raddr (tag_raddr),
            .i_din   (tag_wdata),
            .o_dout  (tag_rdata[w])
        );

        data_array #(
            .DEPTH (SETS)
        ) u_data (
            .clk     (clk),
            .rst     (rst),
            .i_ren   (data_ren),
            .i_raddr (data_raddr),
            .i_wen   (data_wen[w]),
            .i_waddr (data_waddr),
            .i_wdata (data_wdata),
            .o_rdata (data_rdata[w])
        );
    end

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

    localparam int MEM_ADDR_W = 32;
    localparam int MEM_DATA_W = 64;

    // one line is a fixed burst
    localparam int BEATS_PER_LINE = 2;
    localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

endpackage

// File: source/refill_buffer.sv
`timescale 1ns/10ps

module refill_buffer (
    input  logic                           clk,
    input  logic                           rst,
    refill_if.buffer                       rf,
    output logic                           o_mem_req,
    output logic [mem_pkg::MEM_ADDR_W-1:0] o_mem_addr,
    input  logic                           i_mem_ready,
    input  logic [mem_pkg::MEM_DATA_W-1:0] i_mem_rdata,
    input  logic                           i_mem_rvalid,
    input  logic                           i_mem_rlast
);
    import mem_pkg::*;

    logic                                      receiving;
    logic [BEAT_CNT_W-1:0]                     beat_cnt;
    logic [BEATS_PER_LINE-1:0][MEM_DATA_W-1:0] beats;

    // request phase until ready, then beats until rlast
    always_ff @(posedge clk) begin
        if (rst) begin
            o_mem_req <= 1'b0;
            receiving <= 1'b0;
            beat_cnt  <= '0;
        end else if (rf.start) begin
            o_mem_req <= 1'b1;
            receiving <= 1'b0;
            beat_cnt  <= '0;
        end else if (o_mem_req) begin
            if (i_mem_ready) begin
                o_mem_req <= 1'b0;
                receiving <= 1'b1;
            end
        end else if (receiving && i_mem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (i_mem_rlast) begin
                receiving <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf.start) begin
            o_mem_addr <= rf.line_addr;
        end
        // first beat is the low half
        if (receiving && i_mem_rvalid) begin
            beats[beat_cnt] <= i_mem_rdata;
        end
    end

    assign rf.done = receiving && i_mem_rvalid && i_mem_rlast;
    assign rf.line = beats;

endmodule

// File: source/refill_if.sv
`timescale 1ns/10ps

interface refill_if;
    import icache_pkg::*;
    import mem_pkg::*;

    logic                  start;
    logic [MEM_ADDR_W-1:0] line_addr;
    logic                  done;
    logic [LINE_W-1:0]     line;

    modport ctrl (
        output start,
        output line_addr,
        input  done,
        input  line
    );

    // refill side, line stays put until the next start
    modport buffer (
        input  start,
        input  line_addr,
        output done,
        output line
    );

endinterface

// File: source/tagv_array.sv
`timescale 1ns/10ps

module tagv_array #(
    parameter int DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_wen,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    input  icache_pkg::tagv_t        i_din,
    output icache_pkg::tagv_t        o_dout
);
    import icache_pkg::*;

    tagv_t entries [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            // only the valid bits matter after reset
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (i_wen) begin
            entries[i_waddr] <= i_din;
        end
    end

    // async read so the compare fits in the request cycle
    assign o_dout = entries[i_raddr];

endmodule

// File: tests/icache_props.sv
`timescale 1ns/10ps

module icache_props (
    input logic        clk,
    input logic        rst,
    input logic        i_ready,
    input logic        i_valid,
    input logic        i_mem_req,
    input logic [31:0] i_mem_addr,
    input logic        i_mem_ready
);

    int fail_cnt = 0;

    // request phase holds until the memory takes it
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        i_mem_req && !i_mem_ready |=> i_mem_req && $stable(i_mem_addr))
        else begin
            fail_cnt++;
            $error("memory request dropped or address changed before ready");
        end

    a_req_busy: assert property (@(posedge clk) disable iff (rst)
        !(i_mem_req && i_ready))
        else begin
            fail_cnt++;
            $error("memory request while the cache accepts fetches");
        end

    a_valid_rst: assert property (@(posedge clk) rst |=> !i_valid)
        else begin
            fail_cnt++;
            $error("fetch word valid right after reset");
        end

endmodule

bind icache_top icache_props u_props (
    .clk         (clk),
    .rst         (rst),
    .i_ready     (o_ready),
    .i_valid     (o_valid),
    .i_mem_req   (o_mem_req),
    .i_mem_addr  (o_mem_addr),
    .i_mem_ready (i_mem_ready)
);

// File: tests/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_TESTS    = 6;
    localparam int RAND_FETCHES = 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        i_req;
    logic [31:0] i_addr;
    logic        o_ready;
    logic        o_valid;
    logic [63:0] o_rdata;
    logic        o_mem_req;
    logic [31:0] o_mem_addr;
    logic        i_mem_ready;
    logic [63:0] i_mem_rdata;
    logic        i_mem_rvalid;
    logic        i_mem_rlast;

    int          mem_reqs = 0;
    logic [31:0] last_mem_addr;
    logic [31:0] rand_state = 32'd93;
    bit          stall_on = 1'b0;

    // expected tag, valid and recently-used state
    logic [20:0] ref_tag [128][2];
    bit          ref_valid [128][2];
    bit          ref_ru [128];

    icache_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_rdata      (o_rdata),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rlast  (i_mem_rlast)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // one memory word per aligned 8-byte address
    function automatic logic [63:0] mem_word(input logic [31:0] a);
        return {a ^ 32'h5a3c_96e1, ~a + 32'h0101_0101};
    endfunction

    // returns 1 on a predicted miss and updates the expected state
    function automatic bit ref_access(input logic [31:0] addr);
        logic [20:0] tag;
        int          idx;
        int          way;
        tag = addr[31:11];
        idx = addr[10:4];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                ref_ru[idx] = (w == 1);
                return 1'b0;
            end
        end
        way = !ref_valid[idx][0] ? 0 : (!ref_valid[idx][1] ? 1 : (ref_ru[idx] ? 0 : 1));
        ref_valid[idx][way] = 1'b1;
        ref_tag[idx][way] = tag;
        ref_ru[idx] = (way == 1);
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // called 2 ns after an edge and returns in the o_valid cycle
    task automatic fetch(input logic [31:0] addr, output logic miss, output int lat);
        int          reqs_before;
        logic        exp_miss;
        logic [63:0] exp_word;
        reqs_before = mem_reqs;
        exp_miss = ref_access(addr);
        exp_word = mem_word({addr[31:3], 3'b000});
        i_req = 1'b1;
        i_addr = addr;
        while (!o_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        i_req = 1'b0;
        lat = 0;
        while (!o_valid) begin
            check_true(!o_ready, "o_ready high while a miss is still pending");
            lat++;
            @(posedge clk);
            #2;
        end
        miss = (mem_reqs != reqs_before);
        check_value("o_rdata", o_rdata, exp_word);
        check_value("o_mem_req count", mem_reqs - reqs_before, exp_miss);
        if (miss) begin
            check_value("o_mem_addr", last_mem_addr, {addr[31:4], 4'h0});
        end
    endtask

    task automatic fetch_expect(input logic [31:0] addr, input logic exp_miss);
        logic miss;
        int   lat;
        fetch(addr, miss, lat);
        check_value("miss", miss, exp_miss);
        if (!exp_miss) begin
            check_value("hit latency", lat, 0);
        end
    endtask

    task automatic test_cold_miss();
        fetch_expect(32'h0000_1238, 1'b1);
    endtask

    task automatic test_hit_latency();
        logic [31:0] addrs [4];
        int          reqs_before;
        addrs = '{32'h0000_1230, 32'h0000_1238, 32'h0000_1234, 32'h0000_123c};
        fetch_expect(32'h0000_1230, 1'b0);
        reqs_before = mem_reqs;
        // one request per cycle and each word one cycle behind
        for (int i = 0; i <= 4; i++) begin
            if (i > 0) begin
                check_true(o_valid, "o_valid missing during back-to-back hits");
                check_value("o_rdata", o_rdata, mem_word({addrs[i-1][31:3], 3'b000}));
            end
            if (i < 4) begin
                check_true(o_ready, "o_ready low during back-to-back hits");
                i_req = 1'b1;
                i_addr = addrs[i];
                void'(ref_access(addrs[i]));
                @(posedge clk);
                #2;
            end
        end
        i_req = 1'b0;
        check_value("o_mem_req count", mem_reqs - reqs_before, 0);
    endtask

    task automatic test_two_ways();
        fetch_expect(32'h0000_0050, 1'b1);
        fetch_expect(32'h0000_0858, 1'b1);
        for (int i = 0; i < 3; i++) begin
            fetch_expect(32'h0000_0058, 1'b0);
            fetch_expect(32'h0000_0850, 1'b0);
        end
    endtask

    task automatic test_replacement();
        fetch_expect(32'h0000_1090, 1'b1);
        fetch_expect(32'h0000_2090, 1'b1);
        fetch_expect(32'h0000_1098, 1'b0);
        fetch_expect(32'h0000_3090, 1'b1);
        fetch_expect(32'h0000_1090, 1'b0);
        fetch_expect(32'h0000_2098, 1'b1);
    endtask

    task automatic test_stalls();
        stall_on = 1'b1;
        for (int i = 0; i < 6; i++) begin
            fetch_expect(32'h0000_4008 + i * 32'h100, 1'b1);
        end
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic        miss;
        int          lat;
        for (int i = 0; i < RAND_FETCHES; i++) begin
            r = next_rand();
            fetch({16'h0001, 2'b00, r[29:16]}, miss, lat);
        end
    endtask

    // answers a request after a delay with gaps between beats
    always begin : mem_model
        logic [31:0] line;
        logic [31:0] r;
        int          ready_dly;
        int          beat_gap;
        @(posedge clk);
        #2;
        if (o_mem_req) begin
            mem_reqs++;
            line = o_mem_addr;
            last_mem_addr = o_mem_addr;
            ready_dly = 0;
            beat_gap = 0;
            if (stall_on) begin
                r = next_rand();
                ready_dly = r[31:30];
                beat_gap = r[29:28] % 3;
            end
            repeat (ready_dly) begin
                @(posedge clk);
                #2;
            end
            i_mem_ready = 1'b1;
            @(posedge clk);
            #2;
            i_mem_ready = 1'b0;
            for (int k = 0; k < 2; k++) begin
                repeat (beat_gap) begin
                    @(posedge clk);
                    #2;
                end
                i_mem_rvalid = 1'b1;
                i_mem_rdata = mem_word(line + 8 * k);
                i_mem_rlast = (k == 1);
                @(posedge clk);
                #2;
                i_mem_rvalid = 1'b0;
                i_mem_rlast = 1'b0;
            end
        end
    end

    // bound port properties are looked at once per cycle
    always @(negedge clk) begin
        check_true(i_dut.u_props.fail_cnt == 0, "a bound property on the DUT ports failed");
    end

    initial begin : watchdog
        #((NUM_TESTS * 200 + RAND_FETCHES * 20) * CLK_PERIOD);
        $display("timeout, the cache stopped returning fetch words");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin : run
        rst = 1'b1;
        i_req = 1'b0;
        i_addr = '0;
        i_mem_ready = 1'b0;
        i_mem_rdata = '0;
        i_mem_rvalid = 1'b0;
        i_mem_rlast = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        test_cold_miss();
        test_hit_latency();
        test_two_ways();
        test_replacement();
        test_stalls();
        test_random();
        if (i_dut.u_props.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("a bound property on the DUT ports failed");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: verilog.f
source/icache_pkg.sv
source/mem_pkg.sv
source/refill_if.sv
source/tagv_array.sv
source/data_array.sv
source/refill_buffer.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/icache_props.sv
tests/icache_tb.sv
